/* hdl/core_pkg.sv */
package core_pkg;

    // first fetch after reset
    localparam logic [31:0] boot_address = 32'h0000_0000;

    // rv32i major opcodes, instruction bits 6:0
    typedef enum logic [6:0] {
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        branch = 7'b1100011,
        load   = 7'b0000011,
        store  = 7'b0100011,
        op_imm = 7'b0010011,
        op     = 7'b0110011
    } opcode_t;

    // low three bits follow funct3 where an instruction maps directly
    typedef enum logic [3:0] {
        alu_add    = 4'b0000,
        alu_sll    = 4'b0001,
        alu_slt    = 4'b0010,
        alu_sltu   = 4'b0011,
        alu_xor    = 4'b0100,
        alu_srl    = 4'b0101,
        alu_or     = 4'b0110,
        alu_and    = 4'b0111,
        alu_sub    = 4'b1000,
        alu_sra    = 4'b1101,
        alu_pass_b = 4'b1111
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback
    } core_state_t;

endpackage

/* hdl/alu.sv */
`timescale 1ns/100ps

module alu
    import core_pkg::*;
(
    input  alu_op_t     operation,
    input  logic [31:0] operand_a,
    input  logic [31:0] operand_b,
    output logic [31:0] result,
    output logic        zero
);

    logic [4:0] shift_amount;

    assign shift_amount = operand_b[4:0];

    always_comb begin
        case (operation)
            alu_add:    result = operand_a + operand_b;
            alu_sub:    result = operand_a - operand_b;
            alu_sll:    result = operand_a << shift_amount;
            alu_slt:    result = {31'd0, $signed(operand_a) < $signed(operand_b)};
            alu_sltu:   result = {31'd0, operand_a < operand_b};
            alu_xor:    result = operand_a ^ operand_b;
            alu_srl:    result = operand_a >> shift_amount;
            alu_sra:    result = $unsigned($signed(operand_a) >>> shift_amount);
            alu_or:     result = operand_a | operand_b;
            alu_and:    result = operand_a & operand_b;
            // lui
            alu_pass_b: result = operand_b;
            default:    result = '0;
        endcase
    end

    assign zero = (result == 32'd0);

endmodule

/* hdl/register_file.sv */
`timescale 1ns/100ps

module register_file (
    input  logic        clk,
    input  logic        reset,
    input  logic        write_enable,
    input  logic [4:0]  read_address_1,
    input  logic [4:0]  read_address_2,
    input  logic [4:0]  write_address,
    input  logic [31:0] write_data,
    output logic [31:0] read_data_1,
    output logic [31:0] read_data_2
);

    // x0 has no storage
    logic [31:0] registers [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (write_enable && write_address != 5'd0) begin
            registers[write_address] <= write_data;
        end
    end

    assign read_data_1 = (read_address_1 == 5'd0) ? '0 : registers[read_address_1];
    assign read_data_2 = (read_address_2 == 5'd0) ? '0 : registers[read_address_2];

endmodule

/* hdl/immediate_generator.sv */
`timescale 1ns/100ps

module immediate_generator
    import core_pkg::*;
(
    input  logic [31:0] instruction,
    output logic [31:0] immediate
);

    opcode_t    opcode;
    logic [31:0] sign;

    assign opcode = opcode_t'(instruction[6:0]);
    assign sign   = {32{instruction[31]}};

    always_comb begin
        case (opcode)
            load, op_imm, jalr: begin
                immediate = {sign[31:12], instruction[31:20]};
            end
            store: begin
                immediate = {sign[31:12], instruction[31:25], instruction[11:7]};
            end
            branch: begin
                immediate = {sign[31:12], instruction[7], instruction[30:25],
                             instruction[11:8], 1'b0};
            end
            lui, auipc: begin
                immediate = {instruction[31:12], 12'd0};
            end
            jal: begin
                immediate = {sign[31:20], instruction[19:12], instruction[20],
                             instruction[30:21], 1'b0};
            end
            // register-register operations have no immediate
            default: immediate = '0;
        endcase
    end

endmodule

/* hdl/control_unit.sv */
`timescale 1ns/100ps

module control_unit
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        halt,
    input  logic        memory_response,
    input  logic [31:0] instruction,
    input  logic        alu_zero,
    input  logic        alu_result_lsb,
    output logic        memory_read,
    output logic        memory_write,
    output logic        address_source,
    output logic        ir_write,
    output logic        pc_write,
    output logic        pc_source,
    output logic [1:0]  alu_src_a,
    output logic [1:0]  alu_src_b,
    output alu_op_t     alu_op,
    output logic        reg_write,
    output logic [1:0]  reg_source
);

    core_state_t state;
    core_state_t next_state;
    opcode_t     opcode;
    logic [2:0]  funct3;
    logic        read_next;
    logic        write_next;
    logic        fetch_done;
    logic        branch_taken;
    alu_op_t     arith_op;
    alu_op_t     exec_alu_op;
    logic [1:0]  exec_src_a;
    logic [1:0]  exec_src_b;

    assign opcode     = opcode_t'(instruction[6:0]);
    assign funct3     = instruction[14:12];
    assign fetch_done = memory_read && memory_response;

    // lsb carries slt/sltu, zero carries beq/bne; funct3 bit 0 inverts
    assign branch_taken = (funct3[2] ? alu_result_lsb : alu_zero) ^ funct3[0];

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == op && instruction[30]) ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = instruction[30] ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    // operands for execute, held through the memory phase
    always_comb begin
        exec_src_a  = 2'd2;
        exec_src_b  = 2'd1;
        exec_alu_op = alu_add;
        case (opcode)
            lui:    exec_alu_op = alu_pass_b;
            auipc:  exec_src_a  = 2'd1;
            jal:    exec_src_a  = 2'd1;
            branch: begin
                exec_src_b  = 2'd0;
                exec_alu_op = funct3[2] ? (funct3[1] ? alu_sltu : alu_slt) : alu_sub;
            end
            op_imm: exec_alu_op = arith_op;
            op: begin
                exec_src_b  = 2'd0;
                exec_alu_op = arith_op;
            end
            default: ;
        endcase
    end

    always_comb begin
        address_source = 1'b0;
        ir_write       = 1'b0;
        pc_write       = 1'b0;
        pc_source      = 1'b0;
        alu_src_a      = 2'd0;
        alu_src_b      = 2'd2;
        alu_op         = alu_add;
        reg_write      = 1'b0;
        reg_source     = 2'd0;
        case (state)
            st_fetch: begin
                // pc+4 goes straight into the pc on the response
                ir_write = fetch_done;
                pc_write = fetch_done;
            end
            st_decode: begin
                // branch and jal target
                alu_src_a = 2'd1;
                alu_src_b = 2'd1;
            end
            st_execute: begin
                alu_src_a = exec_src_a;
                alu_src_b = exec_src_b;
                alu_op    = exec_alu_op;
                if (opcode == branch) begin
                    pc_write  = branch_taken;
                    pc_source = 1'b1;
                end else if (opcode == jal) begin
                    pc_write  = 1'b1;
                    pc_source = 1'b1;
                end else if (opcode == jalr) begin
                    pc_write = 1'b1;
                end
            end
            st_memory: begin
                address_source = 1'b1;
                alu_src_a      = exec_src_a;
                alu_src_b      = exec_src_b;
                alu_op         = exec_alu_op;
            end
            st_writeback: begin
                reg_write = 1'b1;
                if (opcode == load) begin
                    reg_source = 2'd1;
                end else if (opcode == jal || opcode == jalr) begin
                    reg_source = 2'd2;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        next_state = state;
        read_next  = 1'b0;
        write_next = 1'b0;
        case (state)
            st_fetch: begin
                // halt only counts while no fetch is pending
                read_next = memory_read ? !memory_response : !halt;
                if (fetch_done) begin
                    next_state = st_decode;
                end
            end
            st_decode: next_state = st_execute;
            st_execute: begin
                case (opcode)
                    load: begin
                        next_state = st_memory;
                        read_next  = 1'b1;
                    end
                    store: begin
                        next_state = st_memory;
                        write_next = 1'b1;
                    end
                    lui, auipc, jal, jalr, op_imm, op: next_state = st_writeback;
                    default: next_state = st_fetch;
                endcase
            end
            st_memory: begin
                read_next  = memory_read && !memory_response;
                write_next = memory_write && !memory_response;
                if ((memory_read || memory_write) && memory_response) begin
                    next_state = (opcode == load) ? st_writeback : st_fetch;
                end
            end
            default: next_state = st_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_fetch;
            memory_read  <= 1'b0;
            memory_write <= 1'b0;
        end else begin
            state        <= next_state;
            memory_read  <= read_next;
            memory_write <= write_next;
        end
    end

endmodule

/* hdl/core.sv */
`timescale 1ns/100ps

module core
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        halt,
    input  logic        memory_response,
    input  logic [31:0] read_data,
    output logic        memory_read,
    output logic        memory_write,
    output logic [2:0]  option,
    output logic [31:0] address,
    output logic [31:0] write_data
);

    logic        address_source;
    logic        ir_write;
    logic        pc_write;
    logic        pc_source;
    logic [1:0]  alu_src_a;
    logic [1:0]  alu_src_b;
    alu_op_t     alu_op;
    logic        reg_write;
    logic [1:0]  reg_source;

    logic [31:0] pc;
    logic [31:0] pc_next;
    logic [31:0] old_pc;
    logic [31:0] instruction_register;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] alu_out_register;
    logic [31:0] memory_data;

    logic [31:0] register_read_1;
    logic [31:0] register_read_2;
    logic [31:0] register_write_data;
    logic [31:0] immediate;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic [31:0] shifted_data;
    logic [31:0] load_data;
    logic [31:0] link_address;

    control_unit i_control_unit (
        .clk            (clk),
        .reset          (reset),
        .halt           (halt),
        .memory_response(memory_response),
        .instruction    (instruction_register),
        .alu_zero       (alu_zero),
        .alu_result_lsb (alu_result[0]),
        .memory_read    (memory_read),
        .memory_write   (memory_write),
        .address_source (address_source),
        .ir_write       (ir_write),
        .pc_write       (pc_write),
        .pc_source      (pc_source),
        .alu_src_a      (alu_src_a),
        .alu_src_b      (alu_src_b),
        .alu_op         (alu_op),
        .reg_write      (reg_write),
        .reg_source     (reg_source)
    );

    register_file i_register_file (
        .clk           (clk),
        .reset         (reset),
        .write_enable  (reg_write),
        .read_address_1(instruction_register[19:15]),
        .read_address_2(instruction_register[24:20]),
        .write_address (instruction_register[11:7]),
        .write_data    (register_write_data),
        .read_data_1   (register_read_1),
        .read_data_2   (register_read_2)
    );

    immediate_generator i_immediate_generator (
        .instruction(instruction_register),
        .immediate  (immediate)
    );

    alu i_alu (
        .operation(alu_op),
        .operand_a(operand_a),
        .operand_b(operand_b),
        .result   (alu_result),
        .zero     (alu_zero)
    );

    assign address    = address_source ? alu_out_register : pc;
    assign option     = instruction_register[14:12];
    assign write_data = rs2_value;

    // jalr target has its low bit cleared, pc+4 is unaffected
    assign pc_next      = pc_source ? alu_out_register : {alu_result[31:1], 1'b0};
    assign link_address = old_pc + 32'd4;

    always_comb begin
        case (alu_src_a)
            2'd0:    operand_a = pc;
            2'd1:    operand_a = old_pc;
            default: operand_a = rs1_value;
        endcase
        case (alu_src_b)
            2'd0:    operand_b = rs2_value;
            2'd1:    operand_b = immediate;
            default: operand_b = 32'd4;
        endcase
    end

    // memory returns the aligned word
    assign shifted_data = memory_data >> {alu_out_register[1:0], 3'b000};

    always_comb begin
        case (instruction_register[14:12])
            3'b000:  load_data = {{24{shifted_data[7]}}, shifted_data[7:0]};
            3'b001:  load_data = {{16{shifted_data[15]}}, shifted_data[15:0]};
            3'b100:  load_data = {24'd0, shifted_data[7:0]};
            3'b101:  load_data = {16'd0, shifted_data[15:0]};
            default: load_data = shifted_data;
        endcase
        case (reg_source)
            2'd0:    register_write_data = alu_out_register;
            2'd1:    register_write_data = load_data;
            default: register_write_data = link_address;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc                   <= boot_address;
            instruction_register <= '0;
        end else begin
            if (pc_write) begin
                pc <= pc_next;
            end
            if (ir_write) begin
                instruction_register <= read_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ir_write) begin
            old_pc <= pc;
        end
        if (memory_response) begin
            memory_data <= read_data;
        end
        rs1_value        <= register_read_1;
        rs2_value        <= register_read_2;
        alu_out_register <= alu_result;
    end

endmodule

/* dv/bus_memory.sv */
`timescale 1ns/100ps

module bus_memory (
    input  logic        clk,
    input  logic        reset,
    input  logic        fixed_latency,
    input  logic        memory_read,
    input  logic        memory_write,
    input  logic [2:0]  option,
    input  logic [31:0] address,
    input  logic [31:0] write_data,
    output logic        memory_response,
    output logic [31:0] read_data,
    output logic        store_done
);

    logic [31:0] words [0:1023];
    logic [31:0] lfsr = 32'h5b35;
    logic        busy;
    logic [2:0]  wait_count;
    logic [31:0] last_store_address;
    logic [31:0] last_store_data;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // a program ends with its store to the end marker
    assign store_done = (last_store_address == 32'h3fc);

    always @(posedge clk) begin : model
        logic [2:0]  draw;
        logic [31:0] merged;
        logic [9:0]  index;
        logic        respond_now;
        index       = address[11:2];
        respond_now = 1'b0;
        draw        = 3'd0;
        if (reset) begin
            busy               <= 1'b0;
            memory_response    <= 1'b0;
            last_store_address <= '0;
        end else if (memory_response) begin
            // request is still high at this edge, it drops after the pulse
            memory_response <= 1'b0;
            busy            <= 1'b0;
        end else if (busy) begin
            if (wait_count == 3'd1) begin
                respond_now = 1'b1;
            end else begin
                wait_count <= wait_count - 3'd1;
            end
        end else if (memory_read || memory_write) begin
            if (!fixed_latency) begin
                for (int b = 0; b < 3; b++) begin
                    lfsr    = lfsr_step(lfsr);
                    draw[b] = lfsr[0];
                end
            end
            busy        <= 1'b1;
            wait_count  <= draw;
            respond_now = (draw == 3'd0);
        end
        if (respond_now) begin
            memory_response <= 1'b1;
            read_data       <= words[index];
            if (memory_write) begin
                merged = words[index];
                case (option[1:0])
                    2'd0:    merged[8 * address[1:0] +: 8] = write_data[7:0];
                    2'd1:    merged[16 * address[1] +: 16] = write_data[15:0];
                    default: merged = write_data;
                endcase
                words[index]       <= merged;
                last_store_address <= address;
                last_store_data    <= merged;
            end
        end
    end

endmodule

/* dv/core_tb.sv */
`timescale 1ns/100ps

module core_tb
    import core_pkg::*;
;

    localparam time clock_period = 100ns;
    // instructions executed over all tests, allowing 20 cycles each
    localparam int executed_instructions = 300;
    localparam time watchdog_limit = (executed_instructions * 20 + 500) * clock_period;

    logic        clk;
    logic        reset;
    logic        halt;
    logic        fixed_latency;
    logic        memory_response;
    logic [31:0] read_data;
    logic        memory_read;
    logic        memory_write;
    logic [2:0]  option;
    logic [31:0] address;
    logic [31:0] write_data;
    logic        store_done;
    int          pc_index;

    int f3_table [10]  = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
    bit alt_table [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};

    core i_core (
        .clk            (clk),
        .reset          (reset),
        .halt           (halt),
        .memory_response(memory_response),
        .read_data      (read_data),
        .memory_read    (memory_read),
        .memory_write   (memory_write),
        .option         (option),
        .address        (address),
        .write_data     (write_data)
    );

    bus_memory i_memory (
        .clk            (clk),
        .reset          (reset),
        .fixed_latency  (fixed_latency),
        .memory_read    (memory_read),
        .memory_write   (memory_write),
        .option         (option),
        .address        (address),
        .write_data     (write_data),
        .memory_response(memory_response),
        .read_data      (read_data),
        .store_done     (store_done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clock_period / 2) clk = ~clk;
        end
    end

    initial begin
        #(watchdog_limit);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $fatal(1);
    end

    function automatic logic [31:0] r_type(logic [2:0] f3, bit alt, logic [4:0] rd,
                                           logic [4:0] rs1, logic [4:0] rs2);
        return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_type(opcode_t opc, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(logic [2:0] f3, logic [4:0] rs2,
                                           logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], store};
    endfunction

    function automatic logic [31:0] b_type(logic [2:0] f3, logic [4:0] rs1,
                                           logic [4:0] rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], branch};
    endfunction

    function automatic logic [31:0] u_type(opcode_t opc, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, jal};
    endfunction

    // expected values from the rv32i rules
    function automatic logic [31:0] alu_ref(int f3, bit alt, logic [31:0] x, logic [31:0] y);
        case (f3)
            0:       return alt ? x - y : x + y;
            1:       return x << y[4:0];
            2:       return {31'd0, $signed(x) < $signed(y)};
            3:       return {31'd0, x < y};
            4:       return x ^ y;
            5:       return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            6:       return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic [31:0] store_ref(logic [31:0] old, logic [31:0] value,
                                              int f3, int offset);
        logic [31:0] merged;
        merged = old;
        case (f3)
            0:       merged[8 * offset +: 8] = value[7:0];
            1:       merged[8 * offset +: 16] = value[15:0];
            default: merged = value;
        endcase
        return merged;
    endfunction

    function automatic logic [31:0] load_ref(logic [31:0] word, int f3, int offset);
        logic [31:0] shifted;
        shifted = word >> (8 * offset);
        case (f3)
            0:       return {{24{shifted[7]}}, shifted[7:0]};
            4:       return {24'd0, shifted[7:0]};
            1:       return {{16{shifted[15]}}, shifted[15:0]};
            5:       return {16'd0, shifted[15:0]};
            default: return shifted;
        endcase
    endfunction

    function automatic bit branch_ref(int f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            0:       return a == b;
            1:       return a != b;
            4:       return $signed(a) < $signed(b);
            5:       return $signed(a) >= $signed(b);
            6:       return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] memory_word(logic [31:0] byte_address);
        return i_memory.words[byte_address[11:2]];
    endfunction

    task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic start_program();
        // every word gets a value that depends on its full index
        for (int i = 0; i < 1024; i++) begin
            i_memory.words[i] = {i[9:0], 6'h15, ~i[9:0], 6'h2a};
        end
        pc_index = 0;
    endtask

    task automatic put(logic [31:0] word);
        i_memory.words[pc_index] = word;
        pc_index++;
    endtask

    task automatic run_program(string name, int halt_cycles);
        put(s_type(3'd2, 5'd0, 5'd0, 12'h3fc));
        put(j_type(5'd0, 21'd0));
        @(negedge clk);
        reset = 1'b1;
        halt  = (halt_cycles > 0);
        repeat (4) @(negedge clk);
        reset = 1'b0;
        repeat (halt_cycles) begin
            @(negedge clk);
            if (memory_read) begin
                $display("%s: the core fetched while halt was high", name);
                $display("Test failed");
                $fatal(1);
            end
        end
        halt = 1'b0;
        while (!memory_read) @(negedge clk);
        compare({name, " first fetch"}, boot_address, address);
        while (!store_done) @(negedge clk);
        // the end marker stores x0
        compare({name, " end marker"}, 32'd0, i_memory.last_store_data);
    endtask

    task automatic alu_test(string name, int halt_cycles);
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        a = 32'hf0f0_1234;
        b = 32'h0000_0007;
        start_program();
        i_memory.words[128] = a;
        i_memory.words[129] = b;
        put(i_type(load, 3'd2, 5'd1, 5'd0, 12'h200));
        put(i_type(load, 3'd2, 5'd2, 5'd0, 12'h204));
        for (int k = 0; k < 10; k++) begin
            put(r_type(f3_table[k], alt_table[k], 5'd3, 5'd1, 5'd2));
            put(s_type(3'd2, 5'd3, 5'd0, 12'h300 + 4 * k));
            if (k != 1) begin
                imm = (f3_table[k] % 4 == 1) ? {1'b0, alt_table[k], 10'd7} : 12'hffb;
                put(i_type(op_imm, f3_table[k], 5'd3, 5'd1, imm));
                put(s_type(3'd2, 5'd3, 5'd0, 12'h340 + 4 * k));
            end
        end
        run_program(name, halt_cycles);
        for (int k = 0; k < 10; k++) begin
            compare(name, alu_ref(f3_table[k], alt_table[k], a, b), memory_word(32'h300 + 4 * k));
            if (k != 1) begin
                imm = (f3_table[k] % 4 == 1) ? {1'b0, alt_table[k], 10'd7} : 12'hffb;
                compare(name, alu_ref(f3_table[k], alt_table[k], a, {{20{imm[11]}}, imm}),
                        memory_word(32'h340 + 4 * k));
            end
        end
    endtask

    task automatic load_store_test();
        logic [31:0] value;
        logic [31:0] loaded;
        logic [31:0] old_words [6];
        int          load_f3 [5] = '{0, 4, 1, 5, 2};
        int          n;
        value  = 32'h9a8b_f7c6;
        loaded = 32'h8070_f0e1;
        start_program();
        i_memory.words[129] = value;
        i_memory.words[139] = loaded;
        for (int k = 0; k < 6; k++) begin
            old_words[k] = i_memory.words[132 + k];
        end
        put(i_type(load, 3'd2, 5'd1, 5'd0, 12'h204));
        for (int k = 0; k < 4; k++) begin
            put(s_type(3'd0, 5'd1, 5'd0, 12'h210 + 5 * k));
        end
        put(s_type(3'd1, 5'd1, 5'd0, 12'h220));
        put(s_type(3'd1, 5'd1, 5'd0, 12'h226));
        put(s_type(3'd2, 5'd1, 5'd0, 12'h228));
        n = 0;
        foreach (load_f3[j]) begin
            for (int off = 0; off < 4; off += 1 << (load_f3[j] % 4)) begin
                put(i_type(load, load_f3[j], 5'd3, 5'd0, 12'h22c + off));
                put(s_type(3'd2, 5'd3, 5'd0, 12'h300 + 4 * n));
                n++;
            end
        end
        run_program("load_store", 0);
        for (int k = 0; k < 4; k++) begin
            compare("load_store sb", store_ref(old_words[k], value, 0, k),
                    memory_word(32'h210 + 4 * k));
        end
        compare("load_store sh", store_ref(old_words[4], value, 1, 0), memory_word(32'h220));
        compare("load_store sh", store_ref(old_words[5], value, 1, 2), memory_word(32'h224));
        compare("load_store sw", value, memory_word(32'h228));
        n = 0;
        foreach (load_f3[j]) begin
            for (int off = 0; off < 4; off += 1 << (load_f3[j] % 4)) begin
                compare("load_store load", load_ref(loaded, load_f3[j], off),
                        memory_word(32'h300 + 4 * n));
                n++;
            end
        end
    endtask

    task automatic branch_test();
        int          f3s [6] = '{0, 1, 4, 5, 6, 7};
        logic [4:0]  rs1s [3] = '{5'd4, 5'd5, 5'd4};
        logic [4:0]  rs2s [3] = '{5'd5, 5'd4, 5'd4};
        logic [31:0] values [6];
        start_program();
        values[4] = 32'hffff_fffd;
        values[5] = 32'd5;
        put(i_type(op_imm, 3'd0, 5'd1, 5'd0, 12'd0));
        put(i_type(op_imm, 3'd0, 5'd2, 5'd0, 12'd1));
        put(i_type(op_imm, 3'd0, 5'd3, 5'd0, 12'd11));
        put(r_type(3'd0, 1'b0, 5'd1, 5'd1, 5'd2));
        put(i_type(op_imm, 3'd0, 5'd2, 5'd2, 12'd1));
        put(b_type(3'd1, 5'd2, 5'd3, 13'h1ff8));
        put(s_type(3'd2, 5'd1, 5'd0, 12'h3f0));
        put(i_type(op_imm, 3'd0, 5'd4, 5'd0, 12'hffd));
        put(i_type(op_imm, 3'd0, 5'd5, 5'd0, 12'd5));
        for (int i = 0; i < 6; i++) begin
            for (int p = 0; p < 3; p++) begin
                // flag stays set only when the branch skips the clear
                put(i_type(op_imm, 3'd0, 5'd6, 5'd0, 12'd1));
                put(b_type(f3s[i], rs1s[p], rs2s[p], 13'd8));
                put(i_type(op_imm, 3'd0, 5'd6, 5'd0, 12'd0));
                put(s_type(3'd2, 5'd6, 5'd0, 12'h300 + 4 * (3 * i + p)));
            end
        end
        run_program("branch", 0);
        compare("branch loop sum", 32'd55, memory_word(32'h3f0));
        for (int i = 0; i < 6; i++) begin
            for (int p = 0; p < 3; p++) begin
                compare("branch flag", {31'd0, branch_ref(f3s[i], values[rs1s[p]],
                        values[rs2s[p]])}, memory_word(32'h300 + 4 * (3 * i + p)));
            end
        end
    endtask

    task automatic jump_test();
        int jal_index;
        int jalr_base;
        int auipc_index;
        start_program();
        jal_index = pc_index;
        put(j_type(5'd1, 21'd12));
        put(i_type(op_imm, 3'd0, 5'd7, 5'd0, 12'd1));
        put(i_type(op_imm, 3'd0, 5'd7, 5'd0, 12'd2));
        put(s_type(3'd2, 5'd1, 5'd0, 12'h300));
        put(s_type(3'd2, 5'd7, 5'd0, 12'h304));
        jalr_base = pc_index;
        put(u_type(auipc, 5'd8, 20'd0));
        put(s_type(3'd2, 5'd8, 5'd0, 12'h308));
        // odd offset, the target drops bit 0
        put(i_type(jalr, 3'd0, 5'd9, 5'd8, 12'd21));
        put(i_type(op_imm, 3'd0, 5'd7, 5'd0, 12'd3));
        put(i_type(op_imm, 3'd0, 5'd7, 5'd0, 12'd4));
        put(s_type(3'd2, 5'd9, 5'd0, 12'h30c));
        put(s_type(3'd2, 5'd7, 5'd0, 12'h310));
        put(u_type(lui, 5'd10, 20'habcde));
        put(s_type(3'd2, 5'd10, 5'd0, 12'h314));
        auipc_index = pc_index;
        put(u_type(auipc, 5'd11, 20'h12345));
        put(s_type(3'd2, 5'd11, 5'd0, 12'h318));
        run_program("jump", 0);
        compare("jump jal link", 4 * jal_index + 4, memory_word(32'h300));
        compare("jump jal skip", 32'd0, memory_word(32'h304));
        compare("jump auipc zero", 4 * jalr_base, memory_word(32'h308));
        compare("jump jalr link", 4 * jalr_base + 12, memory_word(32'h30c));
        compare("jump jalr skip", 32'd0, memory_word(32'h310));
        compare("jump lui", 32'habcd_e000, memory_word(32'h314));
        compare("jump auipc", 4 * auipc_index + 32'h1234_5000, memory_word(32'h318));
    endtask

    initial begin
        reset         = 1'b1;
        halt          = 1'b0;
        fixed_latency = 1'b0;
        alu_test("alu", 0);
        load_store_test();
        branch_test();
        jump_test();
        alu_test("halt", 30);
        fixed_latency = 1'b1;
        alu_test("fixed_latency", 0);
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* riscv_multicycle.f */
hdl/core_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/immediate_generator.sv
hdl/control_unit.sv
hdl/core.sv
dv/bus_memory.sv
dv/core_tb.sv
